// File: rob_sys.f
+incdir+rtl
rtl/rob_pkg.sv
rtl/rob_ifs.sv
rtl/dispatch_stage.sv
rtl/rob.sv
rtl/retire_unit.sv
rtl/rob_top.sv
verif/rob_tb.sv

// File: rtl/dispatch_stage.sv
/* lanes must be valid contiguously from lane 0; accept is combinational and drops to 0
   during a flush cycle, the lanes offered then are discarded */
`include "rob_config.svh"

module dispatch_stage (
    input  logic                             clock,
    input  logic                             rst,
    input  logic [`WAYS-1:0]                 valid,
    input  rob_pkg::arn_t [`WAYS-1:0]        dest_arn,
    input  rob_pkg::prn_t [`WAYS-1:0]        dest_prn,
    input  logic [`WAYS-1:0]                 reg_write,
    input  logic [`WAYS-1:0]                 is_branch,
    input  logic [`WAYS-1:0]                 is_store,
    input  rob_pkg::addr_t [`WAYS-1:0]       pc,
    input  rob_pkg::addr_t [`WAYS-1:0]       pred_target,
    input  logic [`WAYS-1:0]                 pred_dir,
    input  logic [`WAYS-1:0]                 halt,
    output logic [`WAYS-1:0]                 accept,
    output rob_pkg::rob_idx_t [`WAYS-1:0]    rob_idx,
    output rob_pkg::rob_cnt_t                credits,
    alloc_if.producer                        alloc
);

    rob_pkg::rob_idx_t  tail;
    rob_pkg::lane_cnt_t n_accept;

    // in-order prefix of valid lanes covered by credits
    always_comb begin
        n_accept = '0;
        for (int i = 0; i < `WAYS; i++) begin
            accept[i] = valid[i] && (i < credits) && !alloc.flush;
            // no gaps, a lane needs every older lane accepted
            if (i > 0) begin
                accept[i] = accept[i] && accept[i-1];
            end
            if (accept[i]) begin
                n_accept = rob_pkg::lane_cnt_t'(i + 1);
            end
        end
    end

    // slot tags and entry packing
    always_comb begin
        for (int i = 0; i < `WAYS; i++) begin
            // wraps modulo ROB_DEPTH by truncation
            rob_idx[i] = rob_pkg::rob_idx_t'(tail + rob_pkg::rob_idx_t'(i));

            alloc.wr_entry[i].dest_arn     = dest_arn[i];
            alloc.wr_entry[i].dest_prn     = dest_prn[i];
            alloc.wr_entry[i].reg_write    = reg_write[i];
            alloc.wr_entry[i].is_branch    = is_branch[i];
            alloc.wr_entry[i].is_store     = is_store[i];
            alloc.wr_entry[i].pc           = pc[i];
            alloc.wr_entry[i].pred_target  = pred_target[i];
            alloc.wr_entry[i].pred_dir     = pred_dir[i];
            alloc.wr_entry[i].halt         = halt[i];
            // fresh entry, not yet completed
            alloc.wr_entry[i].done         = 1'b0;
            alloc.wr_entry[i].mispredicted = 1'b0;
        end
    end

    assign alloc.wr_valid = accept;
    assign alloc.wr_idx   = rob_idx;

    // credits and tail, both restart on flush
    always_ff @(posedge clock) begin
        if (rst || alloc.flush) begin
            credits <= rob_pkg::rob_cnt_t'(`ROB_DEPTH);
            tail    <= '0;
        end else begin
            credits <= credits - rob_pkg::rob_cnt_t'(n_accept)
                       + rob_pkg::rob_cnt_t'(alloc.credit_return);
            tail    <= rob_pkg::rob_idx_t'(tail + n_accept);
        end
    end

endmodule

// File: rtl/retire_unit.sv
/* all outputs registered one cycle after commit; freed_prn is only meaningful on lanes
   that write a register, and reads 0 otherwise */
`include "rob_config.svh"

module retire_unit (
    input  logic                             clock,
    input  logic                             rst,
    commit_if.retire                         commit,
    output logic [`WAYS-1:0]                 ret_valid,
    output rob_pkg::arn_t [`WAYS-1:0]        ret_arn,
    output rob_pkg::prn_t [`WAYS-1:0]        ret_prn,
    output rob_pkg::prn_t [`WAYS-1:0]        ret_freed_prn,
    output logic                             redirect,
    output rob_pkg::addr_t                   redirect_pc,
    output logic                             halted
);

    // architectural register to physical register
    rob_pkg::prn_t arch_map [`ARCH_REGS];
    rob_pkg::prn_t map_next [`ARCH_REGS];
    rob_pkg::prn_t freed [`WAYS];

    // lane 0 first, so a later lane to the same arn frees lane 0's prn
    always_comb begin
        map_next = arch_map;
        for (int i = 0; i < `WAYS; i++) begin
            freed[i] = '0;
            if (commit.valid[i] && commit.reg_write[i]) begin
                freed[i]                 = map_next[commit.arn[i]];
                map_next[commit.arn[i]] = commit.prn[i];
            end
        end
    end

    // map and control outputs
    always_ff @(posedge clock) begin
        if (rst) begin
            // identity mapping
            for (int i = 0; i < `ARCH_REGS; i++) begin
                arch_map[i] <= rob_pkg::prn_t'(i);
            end
            ret_valid <= '0;
            redirect  <= 1'b0;
            halted    <= 1'b0;
        end else begin
            arch_map  <= map_next;
            ret_valid <= commit.valid;
            redirect  <= commit.redirect;
            // sticky until reset
            halted    <= halted | commit.halt;
        end
    end

    // payload outputs
    always_ff @(posedge clock) begin
        for (int i = 0; i < `WAYS; i++) begin
            ret_arn[i]       <= commit.arn[i];
            ret_prn[i]       <= commit.prn[i];
            ret_freed_prn[i] <= freed[i];
        end
        redirect_pc <= commit.redirect_pc;
    end

endmodule

// File: rtl/rob.sv
/* completions are ignored for slots not holding a live entry; at most one store commits
   per cycle, and nothing commits after a halt until reset */
`include "rob_config.svh"

module rob (
    input  logic                             clock,
    input  logic                             rst,
    input  logic [`WAYS-1:0]                 cmp_valid,
    input  rob_pkg::rob_idx_t [`WAYS-1:0]    cmp_idx,
    input  logic [`WAYS-1:0]                 cmp_dir,
    input  rob_pkg::addr_t [`WAYS-1:0]       cmp_target,
    alloc_if.buffer                          alloc,
    commit_if.buffer                         commit
);

    rob_pkg::rob_entry_t entries [`ROB_DEPTH];
    // live entry per slot
    logic [`ROB_DEPTH-1:0] occupied;
    rob_pkg::rob_idx_t     head;
    // set once a halt has committed
    logic                  stopped;

    // head-relative view of the commit window
    rob_pkg::rob_idx_t     lane_slot [`WAYS];
    rob_pkg::rob_entry_t   lane_entry [`WAYS];
    logic [`WAYS-1:0]      lane_ready;

    logic [`WAYS-1:0]      commit_lane;
    rob_pkg::lane_cnt_t    n_commit;
    logic                  flush;
    rob_pkg::addr_t        flush_pc;
    logic                  halt_commit;

    always_comb begin
        for (int i = 0; i < `WAYS; i++) begin
            lane_slot[i]  = rob_pkg::rob_idx_t'(head + rob_pkg::rob_idx_t'(i));
            lane_entry[i] = entries[lane_slot[i]];
            lane_ready[i] = occupied[lane_slot[i]] && lane_entry[i].done;
        end
    end

    // in-order commit selection
    always_comb begin
        logic stop;
        logic store_seen;

        stop        = stopped;
        store_seen  = 1'b0;
        commit_lane = '0;
        n_commit    = '0;
        flush       = 1'b0;
        flush_pc    = '0;
        halt_commit = 1'b0;
        for (int i = 0; i < `WAYS; i++) begin
            // second store in the same cycle waits
            if (!stop && lane_ready[i] && !(lane_entry[i].is_store && store_seen)) begin
                commit_lane[i] = 1'b1;
                n_commit       = rob_pkg::lane_cnt_t'(i + 1);
                store_seen     = store_seen | lane_entry[i].is_store;
                if (lane_entry[i].halt) begin
                    halt_commit = 1'b1;
                    stop        = 1'b1;
                end
                // mispredicted branch commits, younger lanes are squashed
                if (lane_entry[i].is_branch && lane_entry[i].mispredicted) begin
                    flush = 1'b1;
                    stop  = 1'b1;
                    if (lane_entry[i].pred_dir) begin
                        flush_pc = lane_entry[i].pred_target;
                    end else begin
                        flush_pc = lane_entry[i].pc + rob_pkg::addr_t'(4);
                    end
                end
            end else begin
                stop = 1'b1;
            end
        end
    end

    // commit port
    always_comb begin
        for (int i = 0; i < `WAYS; i++) begin
            commit.valid[i]     = commit_lane[i];
            commit.reg_write[i] = commit_lane[i] && lane_entry[i].reg_write;
            commit.arn[i]       = lane_entry[i].dest_arn;
            commit.prn[i]       = lane_entry[i].dest_prn;
        end
    end

    assign commit.redirect    = flush;
    assign commit.redirect_pc = flush_pc;
    assign commit.halt        = halt_commit;

    assign alloc.credit_return = n_commit;
    assign alloc.flush         = flush;

    // head, occupancy and halt state
    always_ff @(posedge clock) begin
        if (rst) begin
            head     <= '0;
            occupied <= '0;
            stopped  <= 1'b0;
        end else if (flush) begin
            // whole buffer squashed, restart at slot 0
            head     <= '0;
            occupied <= '0;
        end else begin
            head    <= rob_pkg::rob_idx_t'(head + n_commit);
            stopped <= stopped | halt_commit;
            for (int i = 0; i < `WAYS; i++) begin
                if (commit_lane[i]) begin
                    occupied[lane_slot[i]] <= 1'b0;
                end
            end
            // credits keep new writes off slots freed this cycle
            for (int i = 0; i < `WAYS; i++) begin
                if (alloc.wr_valid[i]) begin
                    occupied[alloc.wr_idx[i]] <= 1'b1;
                end
            end
        end
    end

    // entry payload, allocation then completion
    always_ff @(posedge clock) begin
        for (int i = 0; i < `WAYS; i++) begin
            if (alloc.wr_valid[i]) begin
                entries[alloc.wr_idx[i]] <= alloc.wr_entry[i];
            end
        end
        for (int i = 0; i < `WAYS; i++) begin
            if (cmp_valid[i] && occupied[cmp_idx[i]]) begin
                entries[cmp_idx[i]].done         <= 1'b1;
                entries[cmp_idx[i]].mispredicted <= entries[cmp_idx[i]].is_branch
                    && (cmp_target[i] != entries[cmp_idx[i]].pred_target);
                // resolved outcome replaces the prediction
                entries[cmp_idx[i]].pred_dir     <= cmp_dir[i];
                entries[cmp_idx[i]].pred_target  <= cmp_target[i];
            end
        end
    end

endmodule

// File: rtl/rob_config.svh
/* sizing for the reorder-buffer subsystem; ROB_DEPTH and WAYS must be powers of two
   so that slot indices wrap by truncation */
`ifndef ROB_CONFIG_SVH
`define ROB_CONFIG_SVH

// entries in the reorder buffer
`define ROB_DEPTH 16

// dispatch and commit lanes per cycle
`define WAYS 2

// instruction address width
`define XLEN 32

// register file sizes
`define ARCH_REGS 32
`define PRF_REGS 64

`endif

// File: rtl/rob_ifs.sv
/* alloc_if carries credit flow control between dispatch and buffer;
   commit_if has no back-pressure, the retire side always takes every lane */
`include "rob_config.svh"

interface alloc_if;

    // per-lane writes into the buffer
    logic [`WAYS-1:0]                  wr_valid;
    rob_pkg::rob_entry_t [`WAYS-1:0]   wr_entry;
    rob_pkg::rob_idx_t [`WAYS-1:0]     wr_idx;

    // entries committed this cycle, added back to credits at the edge
    rob_pkg::lane_cnt_t                credit_return;
    // mispredict flush, restarts credits and tail
    logic                              flush;

    modport producer (
        output wr_valid, wr_entry, wr_idx,
        input  credit_return, flush
    );

    modport buffer (
        input  wr_valid, wr_entry, wr_idx,
        output credit_return, flush
    );

endinterface

interface commit_if;

    // per-lane commit info
    logic [`WAYS-1:0]                  valid;
    logic [`WAYS-1:0]                  reg_write;
    rob_pkg::arn_t [`WAYS-1:0]         arn;
    rob_pkg::prn_t [`WAYS-1:0]         prn;

    // control from the last committing lane
    logic                              redirect;
    rob_pkg::addr_t                    redirect_pc;
    logic                              halt;

    modport buffer (output valid, reg_write, arn, prn, redirect, redirect_pc, halt);
    modport retire (input  valid, reg_write, arn, prn, redirect, redirect_pc, halt);

endinterface

// File: rtl/rob_pkg.sv
/* shared types for dispatch, reorder buffer and retire; widths derive from the config macros */
`include "rob_config.svh"

package rob_pkg;

    // slot index into the buffer
    typedef logic [$clog2(`ROB_DEPTH)-1:0] rob_idx_t;
    // free or used slot count, 0..ROB_DEPTH
    typedef logic [$clog2(`ROB_DEPTH):0] rob_cnt_t;
    // lanes moved in one cycle, 0..WAYS
    typedef logic [$clog2(`WAYS+1)-1:0] lane_cnt_t;

    typedef logic [$clog2(`ARCH_REGS)-1:0] arn_t;
    typedef logic [$clog2(`PRF_REGS)-1:0] prn_t;
    typedef logic [`XLEN-1:0] addr_t;

    // one in-flight instruction
    typedef struct packed {
        arn_t  dest_arn;
        prn_t  dest_prn;
        logic  reg_write;
        logic  is_branch;
        logic  is_store;
        addr_t pc;
        // predicted at dispatch, replaced by the resolved values at completion
        addr_t pred_target;
        logic  pred_dir;
        logic  halt;
        logic  done;
        logic  mispredicted;
    } rob_entry_t;

endpackage

// File: rtl/rob_top.sv
/* dispatch, reorder buffer and retire; disp lanes must be contiguous from lane 0 and a
   completion must arrive at least one cycle after its dispatch edge */
`include "rob_config.svh"

module rob_top (
    input  logic                             clock,
    input  logic                             rst,
    input  logic [`WAYS-1:0]                 disp_valid,
    input  rob_pkg::arn_t [`WAYS-1:0]        disp_dest_arn,
    input  rob_pkg::prn_t [`WAYS-1:0]        disp_dest_prn,
    input  logic [`WAYS-1:0]                 disp_reg_write,
    input  logic [`WAYS-1:0]                 disp_is_branch,
    input  logic [`WAYS-1:0]                 disp_is_store,
    input  rob_pkg::addr_t [`WAYS-1:0]       disp_pc,
    input  rob_pkg::addr_t [`WAYS-1:0]       disp_pred_target,
    input  logic [`WAYS-1:0]                 disp_pred_dir,
    input  logic [`WAYS-1:0]                 disp_halt,
    input  logic [`WAYS-1:0]                 cmp_valid,
    input  rob_pkg::rob_idx_t [`WAYS-1:0]    cmp_rob_idx,
    input  logic [`WAYS-1:0]                 cmp_dir,
    input  rob_pkg::addr_t [`WAYS-1:0]       cmp_target,
    output logic [`WAYS-1:0]                 disp_accept,
    output rob_pkg::rob_idx_t [`WAYS-1:0]    disp_rob_idx,
    output rob_pkg::rob_cnt_t                disp_credits,
    output logic [`WAYS-1:0]                 ret_valid,
    output rob_pkg::arn_t [`WAYS-1:0]        ret_arn,
    output rob_pkg::prn_t [`WAYS-1:0]        ret_prn,
    output rob_pkg::prn_t [`WAYS-1:0]        ret_freed_prn,
    output logic                             redirect,
    output rob_pkg::addr_t                   redirect_pc,
    output logic                             halted
);

    alloc_if  i_alloc ();
    commit_if i_commit ();

    dispatch_stage i_dispatch (
        .clock       (clock),
        .rst         (rst),
        .valid       (disp_valid),
        .dest_arn    (disp_dest_arn),
        .dest_prn    (disp_dest_prn),
        .reg_write   (disp_reg_write),
        .is_branch   (disp_is_branch),
        .is_store    (disp_is_store),
        .pc          (disp_pc),
        .pred_target (disp_pred_target),
        .pred_dir    (disp_pred_dir),
        .halt        (disp_halt),
        .accept      (disp_accept),
        .rob_idx     (disp_rob_idx),
        .credits     (disp_credits),
        .alloc       (i_alloc.producer)
    );

    rob i_rob (
        .clock      (clock),
        .rst        (rst),
        .cmp_valid  (cmp_valid),
        .cmp_idx    (cmp_rob_idx),
        .cmp_dir    (cmp_dir),
        .cmp_target (cmp_target),
        .alloc      (i_alloc.buffer),
        .commit     (i_commit.buffer)
    );

    retire_unit i_retire (
        .clock         (clock),
        .rst           (rst),
        .commit        (i_commit.retire),
        .ret_valid     (ret_valid),
        .ret_arn       (ret_arn),
        .ret_prn       (ret_prn),
        .ret_freed_prn (ret_freed_prn),
        .redirect      (redirect),
        .redirect_pc   (redirect_pc),
        .halted        (halted)
    );

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# build rob_tb with Verilator, run it, and decide pass or fail from the log
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing -Wno-fatal --top-module rob_tb -Mdir "$OBJ" -f rob_sys.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$OBJ/Vrob_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation finished: FAIL" "$LOG"; then
    exit 1
fi
if ! grep -q "Simulation finished: PASS" "$LOG"; then
    echo "simulation ended without a result line"
    exit 1
fi
exit 0

// File: verif/rob_tb.sv
/* directed testbench for rob_top; every test starts from reset, inputs change on the
   falling edge and outputs are sampled there */
`include "rob_config.svh"

module rob_tb;

    localparam int RETIRE_TIMEOUT = 40;
    localparam int QUIET_CYCLES   = 8;

    logic                             clock;
    logic                             rst;
    logic [`WAYS-1:0]                 disp_valid;
    rob_pkg::arn_t [`WAYS-1:0]        disp_dest_arn;
    rob_pkg::prn_t [`WAYS-1:0]        disp_dest_prn;
    logic [`WAYS-1:0]                 disp_reg_write;
    logic [`WAYS-1:0]                 disp_is_branch;
    logic [`WAYS-1:0]                 disp_is_store;
    rob_pkg::addr_t [`WAYS-1:0]       disp_pc;
    rob_pkg::addr_t [`WAYS-1:0]       disp_pred_target;
    logic [`WAYS-1:0]                 disp_pred_dir;
    logic [`WAYS-1:0]                 disp_halt;
    logic [`WAYS-1:0]                 cmp_valid;
    rob_pkg::rob_idx_t [`WAYS-1:0]    cmp_rob_idx;
    logic [`WAYS-1:0]                 cmp_dir;
    rob_pkg::addr_t [`WAYS-1:0]       cmp_target;
    logic [`WAYS-1:0]                 disp_accept;
    rob_pkg::rob_idx_t [`WAYS-1:0]    disp_rob_idx;
    rob_pkg::rob_cnt_t                disp_credits;
    logic [`WAYS-1:0]                 ret_valid;
    rob_pkg::arn_t [`WAYS-1:0]        ret_arn;
    rob_pkg::prn_t [`WAYS-1:0]        ret_prn;
    rob_pkg::prn_t [`WAYS-1:0]        ret_freed_prn;
    logic                             redirect;
    rob_pkg::addr_t                   redirect_pc;
    logic                             halted;

    int value_errors;
    int timeout_errors;
    // allocations since reset give the expected slot
    int n_disp;

    // architectural map model holds the identity after reset
    rob_pkg::prn_t model_map [`ARCH_REGS];
    // retire expectations in program order
    rob_pkg::arn_t exp_arn [$];
    rob_pkg::prn_t exp_prn [$];
    logic          exp_rw [$];

    rob_top i_dut (
        .clock            (clock),
        .rst              (rst),
        .disp_valid       (disp_valid),
        .disp_dest_arn    (disp_dest_arn),
        .disp_dest_prn    (disp_dest_prn),
        .disp_reg_write   (disp_reg_write),
        .disp_is_branch   (disp_is_branch),
        .disp_is_store    (disp_is_store),
        .disp_pc          (disp_pc),
        .disp_pred_target (disp_pred_target),
        .disp_pred_dir    (disp_pred_dir),
        .disp_halt        (disp_halt),
        .cmp_valid        (cmp_valid),
        .cmp_rob_idx      (cmp_rob_idx),
        .cmp_dir          (cmp_dir),
        .cmp_target       (cmp_target),
        .disp_accept      (disp_accept),
        .disp_rob_idx     (disp_rob_idx),
        .disp_credits     (disp_credits),
        .ret_valid        (ret_valid),
        .ret_arn          (ret_arn),
        .ret_prn          (ret_prn),
        .ret_freed_prn    (ret_freed_prn),
        .redirect         (redirect),
        .redirect_pc      (redirect_pc),
        .halted           (halted)
    );

    always #2 clock = ~clock;

    task automatic check_prn(input string name, input rob_pkg::prn_t got,
                             input rob_pkg::prn_t want);
        if (got !== want) begin
            $display("Fail %s: got 0x%0h expected 0x%0h", name, got, want);
            value_errors++;
        end
    endtask

    task automatic check_arn(input string name, input rob_pkg::arn_t got,
                             input rob_pkg::arn_t want);
        if (got !== want) begin
            $display("Fail %s: got 0x%0h expected 0x%0h", name, got, want);
            value_errors++;
        end
    endtask

    task automatic check_addr(input string name, input rob_pkg::addr_t got,
                              input rob_pkg::addr_t want);
        if (got !== want) begin
            $display("Fail %s: got 0x%0h expected 0x%0h", name, got, want);
            value_errors++;
        end
    endtask

    task automatic check_cnt(input string name, input rob_pkg::rob_cnt_t got,
                             input rob_pkg::rob_cnt_t want);
        if (got !== want) begin
            $display("Fail %s: got 0x%0h expected 0x%0h", name, got, want);
            value_errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic want);
        if (got !== want) begin
            $display("Fail %s: got 0x%0h expected 0x%0h", name, got, want);
            value_errors++;
        end
    endtask

    function automatic rob_pkg::arn_t random_arn();
        return rob_pkg::arn_t'($urandom);
    endfunction

    function automatic rob_pkg::prn_t random_prn();
        return rob_pkg::prn_t'($urandom);
    endfunction

    // word aligned with the low 12 bits clear so branch offsets never collide
    function automatic rob_pkg::addr_t random_pc();
        return rob_pkg::addr_t'($urandom) & 32'hffff_f000;
    endfunction

    task automatic idle_inputs();
        disp_valid       = '0;
        disp_dest_arn    = '0;
        disp_dest_prn    = '0;
        disp_reg_write   = '0;
        disp_is_branch   = '0;
        disp_is_store    = '0;
        disp_pc          = '0;
        disp_pred_target = '0;
        disp_pred_dir    = '0;
        disp_halt        = '0;
        cmp_valid        = '0;
        cmp_rob_idx      = '0;
        cmp_dir          = '0;
        cmp_target       = '0;
    endtask

    task automatic apply_reset();
        rst = 1'b1;
        idle_inputs();
        repeat (4) @(posedge clock);
        @(negedge clock);
        rst = 1'b0;
        for (int i = 0; i < `ARCH_REGS; i++) begin
            model_map[i] = rob_pkg::prn_t'(i);
        end
        exp_arn.delete();
        exp_prn.delete();
        exp_rw.delete();
        n_disp = 0;
        // idle state straight out of reset
        check_cnt("disp_credits", disp_credits, rob_pkg::rob_cnt_t'(`ROB_DEPTH));
        check_bit("ret_valid[0]", ret_valid[0], 1'b0);
        check_bit("ret_valid[1]", ret_valid[1], 1'b0);
        check_bit("redirect", redirect, 1'b0);
        check_bit("halted", halted, 1'b0);
    endtask

    task automatic set_disp_lane(input int lane, input rob_pkg::arn_t arn,
                                 input rob_pkg::prn_t prn, input logic rw,
                                 input logic br, input logic st, input rob_pkg::addr_t pc,
                                 input rob_pkg::addr_t tgt, input logic dir, input logic hlt);
        disp_dest_arn[lane]    = arn;
        disp_dest_prn[lane]    = prn;
        disp_reg_write[lane]   = rw;
        disp_is_branch[lane]   = br;
        disp_is_store[lane]    = st;
        disp_pc[lane]          = pc;
        disp_pred_target[lane] = tgt;
        disp_pred_dir[lane]    = dir;
        disp_halt[lane]        = hlt;
    endtask

    // plain register write
    task automatic set_alu_lane(input int lane);
        set_disp_lane(lane, random_arn(), random_prn(), 1'b1, 1'b0, 1'b0,
                      random_pc(), '0, 1'b0, 1'b0);
    endtask

    task automatic set_store_lane(input int lane);
        set_disp_lane(lane, random_arn(), random_prn(), 1'b0, 1'b0, 1'b1,
                      random_pc(), '0, 1'b0, 1'b0);
    endtask

    // offer lanes for one cycle and check accept before the edge
    task automatic dispatch_cycle(input logic [`WAYS-1:0] mask,
                                  input logic [`WAYS-1:0] want_accept);
        disp_valid = mask;
        #1;
        for (int i = 0; i < `WAYS; i++) begin
            check_bit($sformatf("disp_accept[%0d]", i), disp_accept[i], want_accept[i]);
            if (want_accept[i]) begin
                // slots handed out in allocation order wrap at the depth
                check_cnt($sformatf("disp_rob_idx[%0d]", i),
                          rob_pkg::rob_cnt_t'(disp_rob_idx[i]),
                          rob_pkg::rob_cnt_t'(n_disp % `ROB_DEPTH));
                exp_arn.push_back(disp_dest_arn[i]);
                exp_prn.push_back(disp_dest_prn[i]);
                exp_rw.push_back(disp_reg_write[i]);
                n_disp++;
            end
        end
        @(negedge clock);
        disp_valid = '0;
    endtask

    task automatic set_cmp_lane(input int lane, input int slot, input logic dir,
                                input rob_pkg::addr_t tgt);
        cmp_rob_idx[lane] = rob_pkg::rob_idx_t'(slot);
        cmp_dir[lane]     = dir;
        cmp_target[lane]  = tgt;
    endtask

    task automatic complete_cycle(input logic [`WAYS-1:0] mask);
        cmp_valid = mask;
        @(negedge clock);
        cmp_valid = '0;
    endtask

    task automatic wait_retire(output logic found);
        found = 1'b0;
        for (int n = 0; n < RETIRE_TIMEOUT && !found; n++) begin
            @(negedge clock);
            found = (ret_valid != '0);
        end
        if (!found) begin
            $display("timeout: nothing retired within %0d cycles", RETIRE_TIMEOUT);
            timeout_errors++;
        end
    endtask

    // compare one retire cycle against program order and the map model
    task automatic check_retire(input logic [`WAYS-1:0] want_valid);
        rob_pkg::arn_t arn;
        rob_pkg::prn_t prn;
        logic          rw;

        for (int i = 0; i < `WAYS; i++) begin
            check_bit($sformatf("ret_valid[%0d]", i), ret_valid[i], want_valid[i]);
            if (ret_valid[i]) begin
                if (exp_arn.size() == 0) begin
                    $display("lane %0d retired with no instruction left to retire", i);
                    value_errors++;
                end else begin
                    arn = exp_arn.pop_front();
                    prn = exp_prn.pop_front();
                    rw  = exp_rw.pop_front();
                    check_arn($sformatf("ret_arn[%0d]", i), ret_arn[i], arn);
                    check_prn($sformatf("ret_prn[%0d]", i), ret_prn[i], prn);
                    if (rw) begin
                        // old mapping is freed and lane 0 updates the model first
                        check_prn($sformatf("ret_freed_prn[%0d]", i), ret_freed_prn[i],
                                  model_map[arn]);
                        model_map[arn] = prn;
                    end
                end
            end
        end
    endtask

    // nothing may retire or redirect in this window
    task automatic watch_quiet(input int cycles, input logic want_halted);
        for (int n = 0; n < cycles; n++) begin
            @(negedge clock);
            check_bit("ret_valid[0]", ret_valid[0], 1'b0);
            check_bit("ret_valid[1]", ret_valid[1], 1'b0);
            check_bit("redirect", redirect, 1'b0);
            check_bit("halted", halted, want_halted);
        end
    endtask

    task automatic test_in_order_retire();
        logic found;

        apply_reset();
        set_alu_lane(0);
        set_alu_lane(1);
        dispatch_cycle(2'b11, 2'b11);
        check_cnt("disp_credits", disp_credits, rob_pkg::rob_cnt_t'(`ROB_DEPTH - 2));
        // younger slot completes first
        set_cmp_lane(0, 1, 1'b0, '0);
        complete_cycle(2'b01);
        set_cmp_lane(0, 0, 1'b0, '0);
        complete_cycle(2'b01);
        wait_retire(found);
        if (found) begin
            check_retire(2'b11);
            check_cnt("disp_credits", disp_credits, rob_pkg::rob_cnt_t'(`ROB_DEPTH));
        end
    endtask

    task automatic test_credit_limit();
        logic found;

        apply_reset();
        for (int c = 0; c < `ROB_DEPTH / `WAYS; c++) begin
            set_alu_lane(0);
            set_alu_lane(1);
            dispatch_cycle(2'b11, 2'b11);
        end
        check_cnt("disp_credits", disp_credits, '0);
        // full buffer takes nothing
        dispatch_cycle(2'b11, 2'b00);
        set_cmp_lane(0, 0, 1'b0, '0);
        complete_cycle(2'b01);
        wait_retire(found);
        if (found) begin
            check_retire(2'b01);
            check_cnt("disp_credits", disp_credits, rob_pkg::rob_cnt_t'(1));
        end
        // with one credit back only lane 0 fits
        set_alu_lane(0);
        set_alu_lane(1);
        dispatch_cycle(2'b11, 2'b01);
        check_cnt("disp_credits", disp_credits, '0);
    endtask

    task automatic test_store_split();
        logic found;

        apply_reset();
        set_store_lane(0);
        set_store_lane(1);
        dispatch_cycle(2'b11, 2'b11);
        set_cmp_lane(0, 0, 1'b0, '0);
        set_cmp_lane(1, 1, 1'b0, '0);
        complete_cycle(2'b11);
        // one store per cycle and always on lane 0
        wait_retire(found);
        if (found) begin
            check_retire(2'b01);
        end
        wait_retire(found);
        if (found) begin
            check_retire(2'b01);
        end
    endtask

    task automatic test_mispredict(input logic taken);
        rob_pkg::addr_t br_pc;
        rob_pkg::addr_t pred_tgt;
        rob_pkg::addr_t real_tgt;
        rob_pkg::addr_t far_tgt;
        logic           found;

        apply_reset();
        br_pc   = random_pc();
        far_tgt = br_pc + 32'h40 + (rob_pkg::addr_t'($urandom) & 32'h0000_0ffc);
        // resolved target differs from the prediction and from pc plus 4
        pred_tgt = taken ? br_pc + 32'h4 : far_tgt;
        real_tgt = taken ? far_tgt : far_tgt + 32'h40;
        set_disp_lane(0, random_arn(), random_prn(), 1'b0, 1'b1, 1'b0,
                      br_pc, pred_tgt, !taken, 1'b0);
        set_alu_lane(1);
        dispatch_cycle(2'b11, 2'b11);
        set_alu_lane(0);
        set_alu_lane(1);
        dispatch_cycle(2'b11, 2'b11);
        // younger work done before the branch resolves
        set_cmp_lane(0, 1, 1'b0, '0);
        set_cmp_lane(1, 2, 1'b0, '0);
        complete_cycle(2'b11);
        set_cmp_lane(0, 3, 1'b0, '0);
        set_cmp_lane(1, 0, taken, real_tgt);
        complete_cycle(2'b11);
        wait_retire(found);
        if (found) begin
            check_retire(2'b01);
            check_bit("redirect", redirect, 1'b1);
            check_addr("redirect_pc", redirect_pc, taken ? real_tgt : br_pc + 32'h4);
            check_cnt("disp_credits", disp_credits, rob_pkg::rob_cnt_t'(`ROB_DEPTH));
        end
        watch_quiet(QUIET_CYCLES, 1'b0);
    endtask

    task automatic test_halt();
        logic found;

        apply_reset();
        set_disp_lane(0, random_arn(), random_prn(), 1'b1, 1'b0, 1'b0,
                      random_pc(), '0, 1'b0, 1'b1);
        set_alu_lane(1);
        dispatch_cycle(2'b11, 2'b11);
        set_alu_lane(0);
        set_alu_lane(1);
        dispatch_cycle(2'b11, 2'b11);
        set_cmp_lane(0, 2, 1'b0, '0);
        set_cmp_lane(1, 3, 1'b0, '0);
        complete_cycle(2'b11);
        set_cmp_lane(0, 0, 1'b0, '0);
        set_cmp_lane(1, 1, 1'b0, '0);
        complete_cycle(2'b11);
        wait_retire(found);
        if (found) begin
            check_retire(2'b01);
            check_bit("halted", halted, 1'b1);
        end
        // halted is sticky and younger entries stay put
        watch_quiet(QUIET_CYCLES, 1'b1);
    endtask

    initial begin
        clock          = 1'b0;
        rst            = 1'b1;
        value_errors   = 0;
        timeout_errors = 0;
        n_disp         = 0;
        idle_inputs();
        void'($urandom(32'hf853));

        test_in_order_retire();
        test_credit_limit();
        test_store_split();
        test_mispredict(1'b1);
        test_mispredict(1'b0);
        test_halt();

        $display("errors: %0d value mismatches, %0d timeouts", value_errors, timeout_errors);
        if (value_errors == 0 && timeout_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule
